// File: common/ndn_pkg.sv
package ndn_pkg;

    // table and field sizes
    localparam int NAME_W    = 64;
    localparam int LEN_W     = 6;
    localparam int FACES     = 4;
    localparam int PIT_DEPTH = 16;
    localparam int FIB_DEPTH = 8;
    localparam int PIT_IDX_W = $clog2(PIT_DEPTH);
    localparam int FIB_IDX_W = $clog2(FIB_DEPTH);

    typedef logic [NAME_W-1:0]        name_t;       // left aligned, zero below len
    typedef logic [LEN_W-1:0]         name_len_t;   // significant leading bits
    typedef logic [$clog2(FACES)-1:0] face_id_t;
    typedef logic [FACES-1:0]         face_mask_t;  // one bit per face
    typedef logic [PIT_IDX_W-1:0]     pit_idx_t;
    typedef logic [FIB_IDX_W-1:0]     fib_idx_t;

    typedef enum logic {
        interest = 1'b0,
        data     = 1'b1
    } pkt_kind_t;

    typedef enum logic [2:0] {
        forward       = 3'd0,  // new interest sent upstream
        aggregate     = 3'd1,  // already pending, face added
        nack_no_route = 3'd2,
        nack_pit_full = 3'd3,  // slot taken by another name
        satisfy       = 3'd4,  // data consumed the entry
        drop          = 3'd5   // unsolicited data
    } verdict_t;

    // PIT commit operations
    localparam logic [1:0] COMMIT_INSERT = 2'd0;
    localparam logic [1:0] COMMIT_ADD    = 2'd1;
    localparam logic [1:0] COMMIT_REMOVE = 2'd2;

endpackage

// File: common/lookup_if.sv
`timescale 1ns/1ps

// one lookup request and its result, four-phase req/ack
interface lookup_if;
    logic               req;
    logic               ack;
    ndn_pkg::name_t     name;  // held stable while req is high
    ndn_pkg::name_len_t len;
    logic               hit;   // valid once ack is high

    modport requester (
        output req,
        output name,
        output len,
        input  ack,
        input  hit
    );

    modport engine (
        input  req,
        input  name,
        input  len,
        output ack,
        output hit
    );
endinterface

// File: pit/pit_table.sv
`timescale 1ns/1ps

module pit_table (
    input  logic                clk,
    input  logic                arst_n,
    lookup_if.engine            lk,
    input  logic                commit_en,
    input  logic [1:0]          commit_op,
    input  ndn_pkg::name_t      commit_name,
    input  ndn_pkg::name_len_t  commit_len,
    input  ndn_pkg::face_id_t   commit_face,
    output ndn_pkg::face_mask_t faces,
    output logic                busy_other
);

    logic [ndn_pkg::PIT_DEPTH-1:0] valid;
    ndn_pkg::name_t                ent_name  [ndn_pkg::PIT_DEPTH];
    ndn_pkg::name_len_t            ent_len   [ndn_pkg::PIT_DEPTH];
    ndn_pkg::face_mask_t           ent_faces [ndn_pkg::PIT_DEPTH];

    ndn_pkg::pit_idx_t   hash;
    ndn_pkg::pit_idx_t   slot;       // slot of the last lookup, target of commit
    logic                hashed;     // compare stage pending
    logic                same_name;
    ndn_pkg::face_mask_t face_bit;

    // fold the name into a slot number, nibble by nibble
    always_comb begin
        hash = '0;
        for (int i = 0; i < ndn_pkg::NAME_W / ndn_pkg::PIT_IDX_W; i++) begin
            hash ^= lk.name[i*ndn_pkg::PIT_IDX_W +: ndn_pkg::PIT_IDX_W];
        end
    end

    assign same_name = (ent_name[slot] == lk.name) && (ent_len[slot] == lk.len);
    assign face_bit  = ndn_pkg::face_mask_t'(1) << commit_face;

    // lookup handshake, hash then compare
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot       <= '0;
            hashed     <= 1'b0;
            lk.ack     <= 1'b0;
            lk.hit     <= 1'b0;
            busy_other <= 1'b0;
        end else if (lk.req && !lk.ack && !hashed) begin
            slot   <= hash;
            hashed <= 1'b1;
        end else if (hashed) begin
            hashed     <= 1'b0;
            lk.ack     <= 1'b1;
            lk.hit     <= valid[slot] && same_name;
            busy_other <= valid[slot] && !same_name;
        end else if (!lk.req && lk.ack) begin
            lk.ack <= 1'b0;  // req gone, close handshake
        end
    end

    always_ff @(posedge clk) begin
        if (hashed) begin
            faces <= ent_faces[slot];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (commit_en) begin
            case (commit_op)
                ndn_pkg::COMMIT_INSERT: valid[slot] <= 1'b1;
                ndn_pkg::COMMIT_REMOVE: valid[slot] <= 1'b0;
                default: ;  // add face keeps the entry
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (commit_en) begin
            if (commit_op == ndn_pkg::COMMIT_INSERT) begin
                ent_name[slot]  <= commit_name;
                ent_len[slot]   <= commit_len;
                ent_faces[slot] <= face_bit;  // fresh entry, arrival face only
            end else if (commit_op == ndn_pkg::COMMIT_ADD) begin
                ent_faces[slot] <= ent_faces[slot] | face_bit;
            end
        end
    end

    // a commit must target the slot of a finished lookup
    a_commit_outside_lookup : assert property (
        @(posedge clk) disable iff (!arst_n)
        commit_en |-> !lk.req
    );

endmodule

// File: fib/fib_lpm.sv
`timescale 1ns/1ps

module fib_lpm (
    input  logic               clk,
    input  logic               arst_n,
    lookup_if.engine           lk,
    input  logic               route_we,
    input  ndn_pkg::fib_idx_t  route_idx,
    input  ndn_pkg::name_t     route_name,
    input  ndn_pkg::name_len_t route_len,
    input  ndn_pkg::face_id_t  route_face,
    output ndn_pkg::name_len_t match_len,
    output ndn_pkg::face_id_t  match_face
);

    logic [ndn_pkg::FIB_DEPTH-1:0] rt_valid;
    ndn_pkg::name_t                rt_name [ndn_pkg::FIB_DEPTH];
    ndn_pkg::name_len_t            rt_len  [ndn_pkg::FIB_DEPTH];
    ndn_pkg::face_id_t             rt_face [ndn_pkg::FIB_DEPTH];

    logic               scanning;
    ndn_pkg::fib_idx_t  scan_idx;
    logic               found;      // some route matched so far
    ndn_pkg::name_len_t best_len;
    ndn_pkg::face_id_t  best_face;
    ndn_pkg::name_t     len_mask;
    logic               slot_match;
    logic               take;

    // leading route_len bits of the slot under scan
    assign len_mask   = ~(ndn_pkg::name_t'('1) >> rt_len[scan_idx]);
    assign slot_match = rt_valid[scan_idx]
                     && (rt_len[scan_idx] <= lk.len)
                     && (((rt_name[scan_idx] ^ lk.name) & len_mask) == '0);
    // strictly longer only, so the lower slot keeps ties
    assign take       = slot_match && (!found || (rt_len[scan_idx] > best_len));

    assign lk.hit     = found;
    assign match_len  = found ? best_len : '0;
    assign match_face = best_face;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scanning <= 1'b0;
            scan_idx <= '0;
            found    <= 1'b0;
            lk.ack   <= 1'b0;
        end else if (scanning) begin
            if (take) begin
                found <= 1'b1;
            end
            if (scan_idx == ndn_pkg::fib_idx_t'(ndn_pkg::FIB_DEPTH - 1)) begin
                scanning <= 1'b0;
                lk.ack   <= 1'b1;  // last slot folded in this cycle
            end else begin
                scan_idx <= scan_idx + 1'b1;
            end
        end else if (lk.req && !lk.ack) begin
            scanning <= 1'b1;
            scan_idx <= '0;
            found    <= 1'b0;
        end else if (!lk.req && lk.ack) begin
            lk.ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (scanning && take) begin
            best_len  <= rt_len[scan_idx];
            best_face <= rt_face[scan_idx];
        end
    end

    // route table, written only between packets
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rt_valid <= '0;
        end else if (route_we) begin
            rt_valid[route_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (route_we) begin
            rt_name[route_idx] <= route_name;
            rt_len[route_idx]  <= route_len;
            rt_face[route_idx] <= route_face;
        end
    end

    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(lk.ack) |-> lk.req
    );

endmodule

// File: src/forward_decision.sv
`timescale 1ns/1ps

module forward_decision (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_req,
    output logic                in_ack,
    input  ndn_pkg::pkt_kind_t  in_kind,
    input  ndn_pkg::name_t      in_name,
    input  ndn_pkg::name_len_t  in_len,
    input  ndn_pkg::face_id_t   in_face,
    lookup_if.requester         pit_lk,
    lookup_if.requester         fib_lk,
    input  ndn_pkg::face_mask_t pit_faces,
    input  logic                pit_busy_other,
    input  ndn_pkg::name_len_t  fib_len,
    input  ndn_pkg::face_id_t   fib_face,
    output logic                commit_en,
    output logic [1:0]          commit_op,
    output ndn_pkg::name_t      commit_name,
    output ndn_pkg::name_len_t  commit_len,
    output ndn_pkg::face_id_t   commit_face,
    output logic                out_req,
    input  logic                out_ack,
    output ndn_pkg::verdict_t   out_verdict,
    output ndn_pkg::face_mask_t out_faces,
    output ndn_pkg::name_len_t  out_match_len
);

    typedef enum logic [2:0] {
        st_idle, st_accept, st_lookup, st_release, st_commit, st_report, st_wait_ack
    } state_t;

    state_t              state;
    ndn_pkg::pkt_kind_t  pkt_kind;
    ndn_pkg::name_t      pkt_name;
    ndn_pkg::name_len_t  pkt_len;
    ndn_pkg::face_id_t   pkt_face;
    logic                accept_pkt;
    logic                lookups_done;
    logic                do_commit;
    ndn_pkg::verdict_t   verdict_nxt;
    ndn_pkg::face_mask_t faces_nxt;
    logic [1:0]          op_nxt;
    logic                commit_nxt;

    assign accept_pkt   = (state == st_idle) && in_req && !in_ack && !out_ack;
    assign lookups_done = (state == st_lookup) && pit_lk.ack && fib_lk.ack;

    // both engines look up the latched name
    assign pit_lk.name = pkt_name;
    assign pit_lk.len  = pkt_len;
    assign fib_lk.name = pkt_name;
    assign fib_lk.len  = pkt_len;
    assign commit_name = pkt_name;
    assign commit_len  = pkt_len;
    assign commit_face = pkt_face;

    always_comb begin
        verdict_nxt = ndn_pkg::drop;
        faces_nxt   = '0;
        op_nxt      = ndn_pkg::COMMIT_INSERT;
        commit_nxt  = 1'b0;
        if (pkt_kind == ndn_pkg::interest) begin
            if (pit_lk.hit) begin
                verdict_nxt = ndn_pkg::aggregate;
                faces_nxt   = pit_faces | (ndn_pkg::face_mask_t'(1) << pkt_face);
                op_nxt      = ndn_pkg::COMMIT_ADD;
                commit_nxt  = 1'b1;
            end else if (pit_busy_other) begin
                verdict_nxt = ndn_pkg::nack_pit_full;
                faces_nxt   = ndn_pkg::face_mask_t'(1) << pkt_face;
            end else if (!fib_lk.hit) begin
                verdict_nxt = ndn_pkg::nack_no_route;
                faces_nxt   = ndn_pkg::face_mask_t'(1) << pkt_face;
            end else begin
                verdict_nxt = ndn_pkg::forward;
                faces_nxt   = ndn_pkg::face_mask_t'(1) << fib_face;
                commit_nxt  = 1'b1;  // insert with arrival face
            end
        end else if (pit_lk.hit) begin
            verdict_nxt = ndn_pkg::satisfy;
            faces_nxt   = pit_faces;
            op_nxt      = ndn_pkg::COMMIT_REMOVE;
            commit_nxt  = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            in_ack     <= 1'b0;
            pit_lk.req <= 1'b0;
            fib_lk.req <= 1'b0;
            do_commit  <= 1'b0;
            commit_en  <= 1'b0;
            out_req    <= 1'b0;
        end else begin
            if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
            case (state)
                st_idle: if (accept_pkt) state <= st_accept;
                st_accept: begin
                    in_ack     <= 1'b1;
                    pit_lk.req <= 1'b1;  // both lookups start together
                    fib_lk.req <= 1'b1;
                    state      <= st_lookup;
                end
                st_lookup: if (lookups_done) begin
                    pit_lk.req <= 1'b0;
                    fib_lk.req <= 1'b0;
                    do_commit  <= commit_nxt;
                    state      <= st_release;
                end
                st_release: if (!pit_lk.ack && !fib_lk.ack) begin
                    commit_en <= do_commit;
                    state     <= st_commit;
                end
                st_commit: begin
                    commit_en <= 1'b0;  // single cycle pulse
                    out_req   <= 1'b1;
                    state     <= st_report;
                end
                st_report: if (out_ack) begin
                    out_req <= 1'b0;
                    state   <= st_wait_ack;
                end
                st_wait_ack: if (!out_ack) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept_pkt) begin
            pkt_kind <= in_kind;
            pkt_name <= in_name;
            pkt_len  <= in_len;
            pkt_face <= in_face;
        end
        if (lookups_done) begin
            out_verdict   <= verdict_nxt;
            out_faces     <= faces_nxt;
            out_match_len <= (pkt_kind == ndn_pkg::interest) ? fib_len : '0;
            commit_op     <= op_nxt;
        end
    end

    // result held steady under back-pressure
    a_out_held : assert property (
        @(posedge clk) disable iff (!arst_n)
        out_req && !out_ack |=> out_req && $stable(out_verdict) && $stable(out_faces)
    );

endmodule

// File: src/ndn_forwarder.sv
`timescale 1ns/1ps

module ndn_forwarder (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                in_req,
    output logic                in_ack,
    input  ndn_pkg::pkt_kind_t  in_kind,
    input  ndn_pkg::name_t      in_name,
    input  ndn_pkg::name_len_t  in_len,
    input  ndn_pkg::face_id_t   in_face,

    output logic                out_req,
    input  logic                out_ack,
    output ndn_pkg::verdict_t   out_verdict,
    output ndn_pkg::face_mask_t out_faces,
    output ndn_pkg::name_len_t  out_match_len,

    input  logic                route_we,
    input  ndn_pkg::fib_idx_t   route_idx,
    input  ndn_pkg::name_t      route_name,
    input  ndn_pkg::name_len_t  route_len,
    input  ndn_pkg::face_id_t   route_face
);

    lookup_if pit_lk ();
    lookup_if fib_lk ();

    ndn_pkg::face_mask_t pit_faces;       // pit --> decision
    logic                pit_busy_other;  // pit --> decision
    ndn_pkg::name_len_t  fib_len;         // fib --> decision
    ndn_pkg::face_id_t   fib_face;        // fib --> decision
    logic                commit_en;       // decision --> pit
    logic [1:0]          commit_op;
    ndn_pkg::name_t      commit_name;
    ndn_pkg::name_len_t  commit_len;
    ndn_pkg::face_id_t   commit_face;

    forward_decision decision_module (
        .clk            (clk),            // input
        .arst_n         (arst_n),         // input
        .in_req         (in_req),         // input
        .in_ack         (in_ack),         // output
        .in_kind        (in_kind),        // input
        .in_name        (in_name),        // input [63:0]
        .in_len         (in_len),         // input [5:0]
        .in_face        (in_face),        // input [1:0]
        .pit_lk         (pit_lk),         // requester
        .fib_lk         (fib_lk),         // requester
        .pit_faces      (pit_faces),      // input [3:0]
        .pit_busy_other (pit_busy_other), // input
        .fib_len        (fib_len),        // input [5:0]
        .fib_face       (fib_face),       // input [1:0]
        .commit_en      (commit_en),      // output
        .commit_op      (commit_op),      // output [1:0]
        .commit_name    (commit_name),    // output [63:0]
        .commit_len     (commit_len),     // output [5:0]
        .commit_face    (commit_face),    // output [1:0]
        .out_req        (out_req),        // output
        .out_ack        (out_ack),        // input
        .out_verdict    (out_verdict),    // output [2:0]
        .out_faces      (out_faces),      // output [3:0]
        .out_match_len  (out_match_len)   // output [5:0]
    );

    pit_table pit_module (
        .clk         (clk),            // input
        .arst_n      (arst_n),         // input
        .lk          (pit_lk),         // engine
        .commit_en   (commit_en),      // input
        .commit_op   (commit_op),      // input [1:0]
        .commit_name (commit_name),    // input [63:0]
        .commit_len  (commit_len),     // input [5:0]
        .commit_face (commit_face),    // input [1:0]
        .faces       (pit_faces),      // output [3:0]
        .busy_other  (pit_busy_other)  // output
    );

    fib_lpm fib_module (
        .clk        (clk),        // input
        .arst_n     (arst_n),     // input
        .lk         (fib_lk),     // engine
        .route_we   (route_we),   // input
        .route_idx  (route_idx),  // input [2:0]
        .route_name (route_name), // input [63:0]
        .route_len  (route_len),  // input [5:0]
        .route_face (route_face), // input [1:0]
        .match_len  (fib_len),    // output [5:0]
        .match_face (fib_face)    // output [1:0]
    );

endmodule

// File: tb/ndn_forwarder_tb.sv
`timescale 1ns/1ps

module ndn_forwarder_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_LINE = 40;
    localparam int MAX_REC         = 64;

    logic                clk;
    logic                arst_n;
    logic                in_req;
    logic                in_ack;
    ndn_pkg::pkt_kind_t  in_kind;
    ndn_pkg::name_t      in_name;
    ndn_pkg::name_len_t  in_len;
    ndn_pkg::face_id_t   in_face;
    logic                out_req;
    logic                out_ack;
    ndn_pkg::verdict_t   out_verdict;
    ndn_pkg::face_mask_t out_faces;
    ndn_pkg::name_len_t  out_match_len;
    logic                route_we;
    ndn_pkg::fib_idx_t   route_idx;
    ndn_pkg::name_t      route_name;
    ndn_pkg::name_len_t  route_len;
    ndn_pkg::face_id_t   route_face;

    // trace records, route loads and packets in file order
    bit                  rec_route   [MAX_REC];
    ndn_pkg::fib_idx_t   rec_idx     [MAX_REC];
    ndn_pkg::pkt_kind_t  rec_kind    [MAX_REC];
    ndn_pkg::name_t      rec_name    [MAX_REC];
    ndn_pkg::name_len_t  rec_len     [MAX_REC];
    ndn_pkg::face_id_t   rec_face    [MAX_REC];
    ndn_pkg::verdict_t   rec_verdict [MAX_REC];
    ndn_pkg::face_mask_t rec_faces   [MAX_REC];
    ndn_pkg::name_len_t  rec_mlen    [MAX_REC];

    int     n_rec;
    int     n_pkts;
    bit     trace_ready;
    integer seed = 32'h28dc;  // back-pressure delays

    ndn_forwarder dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_req        (in_req),
        .in_ack        (in_ack),
        .in_kind       (in_kind),
        .in_name       (in_name),
        .in_len        (in_len),
        .in_face       (in_face),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_verdict   (out_verdict),
        .out_faces     (out_faces),
        .out_match_len (out_match_len),
        .route_we      (route_we),
        .route_idx     (route_idx),
        .route_name    (route_name),
        .route_len     (route_len),
        .route_face    (route_face)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one cycle, inputs change just after the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string why);
        $display("%0t ns: %s", $time, why);
        abort_run();
    endtask

    task automatic check_verdict(input string sig, input ndn_pkg::verdict_t exp,
                                 input ndn_pkg::verdict_t act);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected %s(%0d) actual %s(%0d)",
                     $time, sig, exp.name(), exp, act.name(), act);
            abort_run();
        end
    endtask

    task automatic check_faces(input string sig, input ndn_pkg::face_mask_t exp,
                               input ndn_pkg::face_mask_t act);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected %b actual %b", $time, sig, exp, act);
            abort_run();
        end
    endtask

    task automatic check_len(input string sig, input ndn_pkg::name_len_t exp,
                             input ndn_pkg::name_len_t act);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected %0d actual %0d", $time, sig, exp, act);
            abort_run();
        end
    endtask

    task automatic load_trace();
        int                 fd;
        int                 code;
        byte                tag;
        logic [8*160-1:0]   rest;
        int                 t_kind;
        int                 t_idx;
        int                 t_len;
        int                 t_face;
        int                 t_verdict;
        int                 t_faces;
        int                 t_mlen;
        ndn_pkg::name_t     t_name;
        fd = $fopen("tb/ndn_trace.txt", "r");
        if (fd == 0) report_problem("cannot open the trace file tb/ndn_trace.txt");
        n_rec = 0;
        code  = $fscanf(fd, " %c", tag);
        while (code == 1) begin
            if (n_rec == MAX_REC) report_problem("trace holds more records than fit");
            if (tag == "#") begin
                code = $fgets(rest, fd);  // skip the comment line
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d %h %d %d", t_idx, t_name, t_len, t_face);
                if (code != 4) report_problem("malformed route line in the trace");
                rec_route[n_rec] = 1'b1;
                rec_idx[n_rec]   = ndn_pkg::fib_idx_t'(t_idx);
                rec_name[n_rec]  = t_name;
                rec_len[n_rec]   = ndn_pkg::name_len_t'(t_len);
                rec_face[n_rec]  = ndn_pkg::face_id_t'(t_face);
                n_rec++;
            end else if (tag == "P") begin
                code = $fscanf(fd, "%d %h %d %d %d %b %d", t_kind, t_name, t_len, t_face,
                               t_verdict, t_faces, t_mlen);
                if (code != 7) report_problem("malformed packet line in the trace");
                if (t_verdict > 5) report_problem("unknown verdict number in the trace");
                rec_route[n_rec]   = 1'b0;
                rec_kind[n_rec]    = (t_kind != 0) ? ndn_pkg::data : ndn_pkg::interest;
                rec_name[n_rec]    = t_name;
                rec_len[n_rec]     = ndn_pkg::name_len_t'(t_len);
                rec_face[n_rec]    = ndn_pkg::face_id_t'(t_face);
                rec_verdict[n_rec] = ndn_pkg::verdict_t'(t_verdict[2:0]);
                rec_faces[n_rec]   = ndn_pkg::face_mask_t'(t_faces);
                rec_mlen[n_rec]    = ndn_pkg::name_len_t'(t_mlen);
                n_rec++;
            end else begin
                report_problem("unknown record tag in the trace");
            end
            code = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
    endtask

    task automatic apply_route(input int i);
        route_we   = 1'b1;
        route_idx  = rec_idx[i];
        route_name = rec_name[i];
        route_len  = rec_len[i];
        route_face = rec_face[i];
        step();
        route_we   = 1'b0;
    endtask

    task automatic check_result(input int i);
        check_verdict("out_verdict", rec_verdict[i], out_verdict);
        check_faces("out_faces", rec_faces[i], out_faces);
        check_len("out_match_len", rec_mlen[i], out_match_len);
    endtask

    task automatic run_packet(input int i);
        int delay;
        in_kind = rec_kind[i];
        in_name = rec_name[i];
        in_len  = rec_len[i];
        in_face = rec_face[i];
        in_req  = 1'b1;
        step();
        while (!in_ack) step();
        in_req = 1'b0;
        while (in_ack) step();
        while (!out_req) step();
        check_result(i);
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            step();
            if (!out_req) report_problem("out_req dropped before out_ack was given");
            check_result(i);  // result must hold while stalled
        end
        out_ack = 1'b1;
        step();
        while (out_req) step();
        out_ack = 1'b0;
        step();
        n_pkts++;
    endtask

    initial begin
        in_req     = 1'b0;
        in_kind    = ndn_pkg::interest;
        in_name    = '0;
        in_len     = '0;
        in_face    = '0;
        out_ack    = 1'b0;
        route_we   = 1'b0;
        route_idx  = '0;
        route_name = '0;
        route_len  = '0;
        route_face = '0;
        arst_n     = 1'b0;
        n_pkts     = 0;
        load_trace();
        trace_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        step();
        for (int i = 0; i < n_rec; i++) begin
            if (rec_route[i]) apply_route(i);
            else run_packet(i);
        end
        if (n_pkts == 0) begin
            report_problem("the trace holds no packets");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    // watchdog, scaled to the trace length
    initial begin
        wait (trace_ready);
        #((RESET_CYCLES + n_rec * CYCLES_PER_LINE) * CLK_PERIOD);
        report_problem("timeout, the DUT stopped answering");
    end

endmodule

// File: tb/ndn_trace.txt
# R idx name(hex) len face
# P kind(0 interest, 1 data) name(hex) len face verdict faces(bin) match_len
P 0 ABCD000000000000 16 3 2 1000 0
P 1 ABCD000000000000 16 3 5 0000 0
R 0 A000000000000000 4 1
R 1 AB00000000000000 8 2
R 2 ABC0000000000000 12 0
P 0 ABCD000000000000 16 3 0 0001 12
P 0 AB70000000000000 12 0 0 0100 8
P 0 A500000000000000 8 1 0 0010 4
P 0 AB00000000000000 8 0 0 0100 8
P 0 5000000000000000 4 2 2 0100 0
R 7 0000000000000000 0 3
P 0 5000000000000000 4 2 0 1000 0
P 0 ABCD000000000000 16 1 1 1010 12
P 0 ABCD000000000000 16 0 1 1011 12
P 1 ABCD000000000000 16 2 4 1011 0
P 1 ABCD000000000000 16 2 5 0000 0
P 0 AC00000000000000 8 1 3 0010 4
P 1 AB70000000000000 12 1 4 0001 0
P 0 AC00000000000000 8 1 0 0010 4
P 1 A500000000000000 8 3 4 0010 0
P 1 FF00000000000000 8 0 5 0000 0
P 1 5000000000000000 4 0 4 0100 0

// File: all.f
common/ndn_pkg.sv
common/lookup_if.sv
pit/pit_table.sv
fib/fib_lpm.sv
src/forward_decision.sv
src/ndn_forwarder.sv
tb/ndn_forwarder_tb.sv

// File: run.sh
#!/bin/sh
# build and run the forwarder testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ndn_sim

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module ndn_forwarder_tb --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
